// ==== hdl/act_ram_pkg.sv ====
package act_ram_pkg;

    // Controller phase encoding
    localparam int PHASE_W = 2;

    localparam logic [PHASE_W-1:0] PHASE_IDLE    = 2'd0;
    localparam logic [PHASE_W-1:0] PHASE_LOAD    = 2'd1;  // DRAM stream into input bank
    localparam logic [PHASE_W-1:0] PHASE_COMPUTE = 2'd2;  // Windows out to multipliers
    localparam logic [PHASE_W-1:0] PHASE_DRAIN   = 2'd3;  // PPU results into output bank

    // Signed activation value
    localparam int DATA_W = 16;

    // Position of a nonzero inside its row
    localparam int INDEX_W = 4;

endpackage

// ==== hdl/phase_decode.sv ====
`timescale 1ns/1ps

module phase_decode (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [act_ram_pkg::PHASE_W-1:0] phase,
    input  logic                            layer_parity,
    input  logic                            busy,
    output logic                            load_en,
    output logic                            drain_en,
    output logic                            fetch_en,
    output logic                            clear_ptrs,
    output logic                            in_bank
);

    logic [act_ram_pkg::PHASE_W-1:0] last_phase;
    logic                            in_compute;

    assign in_compute = (phase == act_ram_pkg::PHASE_COMPUTE);

    // Busy freezes every action
    assign load_en  = (phase == act_ram_pkg::PHASE_LOAD) && !busy;
    assign drain_en = (phase == act_ram_pkg::PHASE_DRAIN) && !busy;
    assign fetch_en = in_compute && !busy;

    // Entry into compute, seen on the first unstalled cycle
    assign clear_ptrs = fetch_en && (last_phase != act_ram_pkg::PHASE_COMPUTE);

    assign in_bank = layer_parity;  // Even layers read bank 0

    // Phase of the last cycle that was not stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            last_phase <= act_ram_pkg::PHASE_IDLE;
        end else if (!busy) begin
            last_phase <= phase;
        end
    end

endmodule

// ==== hdl/activation_banks.sv ====
`timescale 1ns/1ps

module activation_banks #(
    parameter int NUM_CHANNELS = 4,
    parameter int DEPTH        = 16,
    parameter int MUL_LANES    = 4,
    parameter int LOAD_LANES   = 2,
    parameter int PPU_LANES    = 2
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            load_en,
    input  logic                                            drain_en,
    input  logic                                            clear_ptrs,
    input  logic                                            in_bank,
    input  logic [LOAD_LANES-1:0]                           load_valid,
    input  logic [LOAD_LANES-1:0][act_ram_pkg::DATA_W-1:0]  load_data,
    input  logic [LOAD_LANES-1:0][act_ram_pkg::INDEX_W-1:0] load_index,
    input  logic [$clog2(NUM_CHANNELS)-1:0]                 load_channel,
    input  logic [PPU_LANES-1:0]                            ppu_valid,
    input  logic [PPU_LANES-1:0][act_ram_pkg::DATA_W-1:0]   ppu_data,
    input  logic [PPU_LANES-1:0][act_ram_pkg::INDEX_W-1:0]  ppu_index,
    input  logic [$clog2(NUM_CHANNELS)-1:0]                 ppu_channel,
    input  logic                                            count_valid,
    input  logic [$clog2(DEPTH):0]                          count_value,
    input  logic [$clog2(NUM_CHANNELS)-1:0]                 fetch_channel,
    input  logic [$clog2(DEPTH)-1:0]                        fetch_base,
    output logic [MUL_LANES-1:0][act_ram_pkg::DATA_W-1:0]   win_data,
    output logic [MUL_LANES-1:0][act_ram_pkg::INDEX_W-1:0]  win_index,
    output logic [NUM_CHANNELS-1:0][$clog2(DEPTH):0]        compressed_counts
);

    localparam int AW = $clog2(DEPTH);

    // Bank, channel, entry
    logic signed [act_ram_pkg::DATA_W-1:0] val_mem [2][NUM_CHANNELS][DEPTH];
    logic [act_ram_pkg::INDEX_W-1:0]       idx_mem [2][NUM_CHANNELS][DEPTH];

    logic [AW-1:0] load_ptr  [NUM_CHANNELS];
    logic [AW-1:0] drain_ptr [NUM_CHANNELS];
    logic [AW-1:0] rd_addr   [MUL_LANES];
    logic          out_bank;

    assign out_bank = ~in_bank;

    // Slot of a lane: base plus the valid lanes below it, wrapping at DEPTH
    function automatic logic [AW-1:0] lane_slot(input logic [AW-1:0] base,
                                                input logic [31:0]   valid,
                                                input int            lane);
        logic [AW-1:0] pos;
        pos = base;
        for (int k = 0; k < lane; k++) begin
            pos = pos + AW'(valid[k]);
        end
        return pos;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                load_ptr[c]          <= '0;
                drain_ptr[c]         <= '0;
                compressed_counts[c] <= '0;
                for (int e = 0; e < DEPTH; e++) begin
                    val_mem[0][c][e] <= '0;
                    val_mem[1][c][e] <= '0;
                    idx_mem[0][c][e] <= '0;
                    idx_mem[1][c][e] <= '0;
                end
            end
        end else begin
            if (clear_ptrs) begin
                for (int c = 0; c < NUM_CHANNELS; c++) begin
                    load_ptr[c]  <= '0;
                    drain_ptr[c] <= '0;
                end
            end
            if (load_en) begin
                for (int i = 0; i < LOAD_LANES; i++) begin
                    if (load_valid[i]) begin
                        val_mem[in_bank][load_channel][lane_slot(load_ptr[load_channel],
                            32'(load_valid), i)] <= load_data[i];
                        idx_mem[in_bank][load_channel][lane_slot(load_ptr[load_channel],
                            32'(load_valid), i)] <= load_index[i];
                    end
                end
                load_ptr[load_channel] <= lane_slot(load_ptr[load_channel],
                                                    32'(load_valid), LOAD_LANES);
            end
            if (drain_en) begin
                for (int i = 0; i < PPU_LANES; i++) begin
                    if (ppu_valid[i]) begin
                        val_mem[out_bank][ppu_channel][lane_slot(drain_ptr[ppu_channel],
                            32'(ppu_valid), i)] <= ppu_data[i];
                        idx_mem[out_bank][ppu_channel][lane_slot(drain_ptr[ppu_channel],
                            32'(ppu_valid), i)] <= ppu_index[i];
                    end
                end
                drain_ptr[ppu_channel] <= lane_slot(drain_ptr[ppu_channel],
                                                    32'(ppu_valid), PPU_LANES);
                if (count_valid) begin
                    compressed_counts[ppu_channel] <= count_value;
                end
            end
        end
    end

    // Unregistered window read from the input bank
    always_comb begin
        for (int i = 0; i < MUL_LANES; i++) begin
            rd_addr[i]   = fetch_base + AW'(i);  // Wraps within the channel
            win_data[i]  = val_mem[in_bank][fetch_channel][rd_addr[i]];
            win_index[i] = idx_mem[in_bank][fetch_channel][rd_addr[i]];
        end
    end

endmodule

// ==== hdl/window_fetch.sv ====
`timescale 1ns/1ps

module window_fetch #(
    parameter int MUL_LANES = 4
) (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           fetch_en,
    input  logic [$clog2(MUL_LANES):0]                     fetch_remain,
    input  logic                                           fetch_full,
    input  logic [MUL_LANES-1:0][act_ram_pkg::DATA_W-1:0]  win_data,
    input  logic [MUL_LANES-1:0][act_ram_pkg::INDEX_W-1:0] win_index,
    output logic [MUL_LANES-1:0][act_ram_pkg::DATA_W-1:0]  fetch_data,
    output logic [MUL_LANES-1:0][act_ram_pkg::INDEX_W-1:0] fetch_index,
    output logic [MUL_LANES-1:0]                           fetch_valid
);

    logic [MUL_LANES-1:0] lane_mask;

    // Thermometer mask, lane 0 upward
    always_comb begin
        for (int i = 0; i < MUL_LANES; i++) begin
            lane_mask[i] = fetch_en && (fetch_full || (i < int'(fetch_remain)));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_valid <= '0;
        end else begin
            fetch_valid <= lane_mask;  // Zero when no fetch this cycle
        end
    end

    // Window payload, meaningful only under fetch_valid
    always_ff @(posedge clk) begin
        if (fetch_en) begin
            fetch_data  <= win_data;
            fetch_index <= win_index;
        end
    end

endmodule

// ==== hdl/act_ram_top.sv ====
`timescale 1ns/1ps

module act_ram_top #(
    parameter int NUM_CHANNELS = 4,
    parameter int DEPTH        = 16,
    parameter int MUL_LANES    = 4,
    parameter int LOAD_LANES   = 2,
    parameter int PPU_LANES    = 2
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic [act_ram_pkg::PHASE_W-1:0]                 phase,
    input  logic                                            layer_parity,
    input  logic                                            busy,
    input  logic [LOAD_LANES-1:0]                           load_valid,
    input  logic [LOAD_LANES-1:0][act_ram_pkg::DATA_W-1:0]  load_data,
    input  logic [LOAD_LANES-1:0][act_ram_pkg::INDEX_W-1:0] load_index,
    input  logic [$clog2(NUM_CHANNELS)-1:0]                 load_channel,
    input  logic [$clog2(NUM_CHANNELS)-1:0]                 fetch_channel,
    input  logic [$clog2(DEPTH)-1:0]                        fetch_base,
    input  logic [$clog2(MUL_LANES):0]                      fetch_remain,
    input  logic                                            fetch_full,
    input  logic [PPU_LANES-1:0]                            ppu_valid,
    input  logic [PPU_LANES-1:0][act_ram_pkg::DATA_W-1:0]   ppu_data,
    input  logic [PPU_LANES-1:0][act_ram_pkg::INDEX_W-1:0]  ppu_index,
    input  logic [$clog2(NUM_CHANNELS)-1:0]                 ppu_channel,
    input  logic                                            count_valid,
    input  logic [$clog2(DEPTH):0]                          count_value,
    output logic [MUL_LANES-1:0][act_ram_pkg::DATA_W-1:0]   fetch_data,
    output logic [MUL_LANES-1:0][act_ram_pkg::INDEX_W-1:0]  fetch_index,
    output logic [MUL_LANES-1:0]                            fetch_valid,
    output logic [NUM_CHANNELS-1:0][$clog2(DEPTH):0]        compressed_counts
);

    logic load_en;
    logic drain_en;
    logic fetch_en;
    logic clear_ptrs;
    logic in_bank;

    logic [MUL_LANES-1:0][act_ram_pkg::DATA_W-1:0]  win_data;
    logic [MUL_LANES-1:0][act_ram_pkg::INDEX_W-1:0] win_index;

    phase_decode u_decode (
        .clk          (clk),
        .rst          (rst),
        .phase        (phase),
        .layer_parity (layer_parity),
        .busy         (busy),
        .load_en      (load_en),
        .drain_en     (drain_en),
        .fetch_en     (fetch_en),
        .clear_ptrs   (clear_ptrs),
        .in_bank      (in_bank)
    );

    activation_banks #(
        .NUM_CHANNELS (NUM_CHANNELS),
        .DEPTH        (DEPTH),
        .MUL_LANES    (MUL_LANES),
        .LOAD_LANES   (LOAD_LANES),
        .PPU_LANES    (PPU_LANES)
    ) u_banks (
        .clk               (clk),
        .rst               (rst),
        .load_en           (load_en),
        .drain_en          (drain_en),
        .clear_ptrs        (clear_ptrs),
        .in_bank           (in_bank),
        .load_valid        (load_valid),
        .load_data         (load_data),
        .load_index        (load_index),
        .load_channel      (load_channel),
        .ppu_valid         (ppu_valid),
        .ppu_data          (ppu_data),
        .ppu_index         (ppu_index),
        .ppu_channel       (ppu_channel),
        .count_valid       (count_valid),
        .count_value       (count_value),
        .fetch_channel     (fetch_channel),
        .fetch_base        (fetch_base),
        .win_data          (win_data),
        .win_index         (win_index),
        .compressed_counts (compressed_counts)
    );

    window_fetch #(
        .MUL_LANES (MUL_LANES)
    ) u_fetch (
        .clk          (clk),
        .rst          (rst),
        .fetch_en     (fetch_en),
        .fetch_remain (fetch_remain),
        .fetch_full   (fetch_full),
        .win_data     (win_data),
        .win_index    (win_index),
        .fetch_data   (fetch_data),
        .fetch_index  (fetch_index),
        .fetch_valid  (fetch_valid)
    );

endmodule

// ==== bench/act_ram_props.sv ====
`timescale 1ns/1ps

module act_ram_props #(
    parameter int MUL_LANES = 4
) (
    input logic                            clk,
    input logic                            rst,
    input logic [act_ram_pkg::PHASE_W-1:0] phase,
    input logic                            busy,
    input logic [MUL_LANES-1:0]            fetch_valid
);

    int assert_fails = 0;

    // Reset leaves no lane valid
    valid_after_reset: assert property (@(posedge clk) rst |=> fetch_valid == '0)
        else begin
            assert_fails++;
            $error("fetch_valid not cleared by reset");
        end

    // Lanes fill from lane 0 upward with no gaps
    valid_contiguous: assert property (@(posedge clk) disable iff (rst)
        (fetch_valid & (fetch_valid + 1'b1)) == '0)
        else begin
            assert_fails++;
            $error("fetch_valid is not a run of ones from lane 0");
        end

    no_fetch_no_valid: assert property (@(posedge clk) disable iff (rst)
        (phase != act_ram_pkg::PHASE_COMPUTE || busy) |=> fetch_valid == '0)
        else begin
            assert_fails++;
            $error("fetch_valid set without a fetch in the previous cycle");
        end

endmodule

bind act_ram_top act_ram_props #(.MUL_LANES(MUL_LANES)) u_props (
    .clk         (clk),
    .rst         (rst),
    .phase       (phase),
    .busy        (busy),
    .fetch_valid (fetch_valid)
);

// ==== bench/act_ram_model.svh ====
`ifndef ACT_RAM_MODEL_SVH
`define ACT_RAM_MODEL_SVH

// Mirror of both banks, the write pointers and the count table
logic [act_ram_pkg::DATA_W-1:0]  m_val [2][NCH][DEPTH];
logic [act_ram_pkg::INDEX_W-1:0] m_idx [2][NCH][DEPTH];
int                              m_lptr [NCH];
int                              m_dptr [NCH];
logic [AW:0]                     m_cnt  [NCH];
logic [act_ram_pkg::PHASE_W-1:0] m_last;

// Window expected on the cycle after a fetch
logic [MUL_LANES-1:0]            exp_valid;
logic [act_ram_pkg::DATA_W-1:0]  exp_data  [MUL_LANES];
logic [act_ram_pkg::INDEX_W-1:0] exp_index [MUL_LANES];

task automatic model_reset();
    for (int c = 0; c < NCH; c++) begin
        m_lptr[c] = 0;
        m_dptr[c] = 0;
        m_cnt[c]  = '0;
        for (int e = 0; e < DEPTH; e++) begin
            m_val[0][c][e] = '0;
            m_val[1][c][e] = '0;
            m_idx[0][c][e] = '0;
            m_idx[1][c][e] = '0;
        end
    end
    m_last    = act_ram_pkg::PHASE_IDLE;
    exp_valid = '0;
endtask

// Uses the bank contents before this cycle's writes
task automatic model_predict();
    int addr;
    exp_valid = '0;
    if (phase == act_ram_pkg::PHASE_COMPUTE && !busy) begin
        for (int i = 0; i < MUL_LANES; i++) begin
            addr         = (int'(fetch_base) + i) % DEPTH;
            exp_data[i]  = m_val[layer_parity][fetch_channel][addr];
            exp_index[i] = m_idx[layer_parity][fetch_channel][addr];
            exp_valid[i] = fetch_full || (i < int'(fetch_remain));
        end
    end
endtask

task automatic model_update();
    if (busy) begin
        return;  // Nothing moves on a stall
    end
    if (phase == act_ram_pkg::PHASE_COMPUTE && m_last != act_ram_pkg::PHASE_COMPUTE) begin
        for (int c = 0; c < NCH; c++) begin
            m_lptr[c] = 0;
            m_dptr[c] = 0;
        end
    end
    if (phase == act_ram_pkg::PHASE_LOAD) begin
        for (int i = 0; i < LOAD_LANES; i++) begin
            if (load_valid[i]) begin
                m_val[layer_parity][load_channel][m_lptr[load_channel]] = load_data[i];
                m_idx[layer_parity][load_channel][m_lptr[load_channel]] = load_index[i];
                m_lptr[load_channel] = (m_lptr[load_channel] + 1) % DEPTH;
            end
        end
    end
    if (phase == act_ram_pkg::PHASE_DRAIN) begin
        for (int i = 0; i < PPU_LANES; i++) begin
            if (ppu_valid[i]) begin
                m_val[!layer_parity][ppu_channel][m_dptr[ppu_channel]] = ppu_data[i];
                m_idx[!layer_parity][ppu_channel][m_dptr[ppu_channel]] = ppu_index[i];
                m_dptr[ppu_channel] = (m_dptr[ppu_channel] + 1) % DEPTH;
            end
        end
        if (count_valid) begin
            m_cnt[ppu_channel] = count_value;
        end
    end
    m_last = phase;
endtask

`endif

// ==== bench/tb_act_ram.sv ====
`timescale 1ns/1ps

module tb_act_ram;

    localparam int NCH        = 4;
    localparam int DEPTH      = 16;
    localparam int MUL_LANES  = 4;
    localparam int LOAD_LANES = 2;
    localparam int PPU_LANES  = 2;
    localparam int AW         = $clog2(DEPTH);
    localparam int CW         = $clog2(NCH);

    localparam int TOTAL_STEPS     = 40 + 30 + 30 + 30 + 20 + 10 + 10 + 4;
    localparam int WATCHDOG_CYCLES = 100 + 40 * TOTAL_STEPS;

    logic                                            clk;
    logic                                            rst;
    logic [act_ram_pkg::PHASE_W-1:0]                 phase;
    logic                                            layer_parity;
    logic                                            busy;
    logic [LOAD_LANES-1:0]                           load_valid;
    logic [LOAD_LANES-1:0][act_ram_pkg::DATA_W-1:0]  load_data;
    logic [LOAD_LANES-1:0][act_ram_pkg::INDEX_W-1:0] load_index;
    logic [CW-1:0]                                   load_channel;
    logic [CW-1:0]                                   fetch_channel;
    logic [AW-1:0]                                   fetch_base;
    logic [$clog2(MUL_LANES):0]                      fetch_remain;
    logic                                            fetch_full;
    logic [PPU_LANES-1:0]                            ppu_valid;
    logic [PPU_LANES-1:0][act_ram_pkg::DATA_W-1:0]   ppu_data;
    logic [PPU_LANES-1:0][act_ram_pkg::INDEX_W-1:0]  ppu_index;
    logic [CW-1:0]                                   ppu_channel;
    logic                                            count_valid;
    logic [AW:0]                                     count_value;
    logic [MUL_LANES-1:0][act_ram_pkg::DATA_W-1:0]   fetch_data;
    logic [MUL_LANES-1:0][act_ram_pkg::INDEX_W-1:0]  fetch_index;
    logic [MUL_LANES-1:0]                            fetch_valid;
    logic [NCH-1:0][AW:0]                            compressed_counts;

    integer seed;

    `include "act_ram_model.svh"

    act_ram_top #(
        .NUM_CHANNELS (NCH),
        .DEPTH        (DEPTH),
        .MUL_LANES    (MUL_LANES),
        .LOAD_LANES   (LOAD_LANES),
        .PPU_LANES    (PPU_LANES)
    ) dut (
        .clk               (clk),
        .rst               (rst),
        .phase             (phase),
        .layer_parity      (layer_parity),
        .busy              (busy),
        .load_valid        (load_valid),
        .load_data         (load_data),
        .load_index        (load_index),
        .load_channel      (load_channel),
        .fetch_channel     (fetch_channel),
        .fetch_base        (fetch_base),
        .fetch_remain      (fetch_remain),
        .fetch_full        (fetch_full),
        .ppu_valid         (ppu_valid),
        .ppu_data          (ppu_data),
        .ppu_index         (ppu_index),
        .ppu_channel       (ppu_channel),
        .count_valid       (count_valid),
        .count_value       (count_value),
        .fetch_data        (fetch_data),
        .fetch_index       (fetch_index),
        .fetch_valid       (fetch_valid),
        .compressed_counts (compressed_counts)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t signal=%s got=%0h expected=%0h", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic check_assertions();
        if (dut.u_props.assert_fails != 0) begin
            $display("ERROR: a bound assertion on the DUT outputs failed at time %0t", $time);
            $display("Verification failed");
            $fatal(1, "Stopped at first assertion failure");
        end
    endtask

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // New inputs at the rising edge, all fields random
    task automatic drive_random(input logic [act_ram_pkg::PHASE_W-1:0] ph, input logic par,
                                input int busy_pct);
        @(posedge clk);
        phase         <= ph;
        layer_parity  <= par;
        busy          <= (rand_below(100) < busy_pct);
        load_valid    <= $random(seed);
        load_data     <= $random(seed);
        load_index    <= $random(seed);
        load_channel  <= $random(seed);
        fetch_channel <= $random(seed);
        fetch_base    <= $random(seed);
        fetch_remain  <= rand_below(6);
        fetch_full    <= (rand_below(4) == 0);
        ppu_valid     <= $random(seed);
        ppu_data      <= $random(seed);
        ppu_index     <= $random(seed);
        ppu_channel   <= $random(seed);
        count_valid   <= $random(seed);
        count_value   <= $random(seed);
    endtask

    // Mid-cycle: compare last cycle's results, then advance the model
    task automatic settle();
        @(negedge clk);
        check_assertions();
        check_value("fetch_valid", fetch_valid, exp_valid);
        for (int i = 0; i < MUL_LANES; i++) begin
            if (exp_valid[i]) begin
                check_value($sformatf("fetch_data[%0d]", i), fetch_data[i], exp_data[i]);
                check_value($sformatf("fetch_index[%0d]", i), fetch_index[i], exp_index[i]);
            end
        end
        for (int c = 0; c < NCH; c++) begin
            check_value($sformatf("compressed_counts[%0d]", c), compressed_counts[c], m_cnt[c]);
            check_value($sformatf("load_ptr[%0d]", c), dut.u_banks.load_ptr[c], m_lptr[c]);
            check_value($sformatf("drain_ptr[%0d]", c), dut.u_banks.drain_ptr[c], m_dptr[c]);
        end
        model_predict();
        model_update();
    endtask

    task automatic run_phase(input logic [act_ram_pkg::PHASE_W-1:0] ph, input logic par,
                             input int cycles, input int busy_pct);
        repeat (cycles) begin
            drive_random(ph, par, busy_pct);
            settle();
        end
    endtask

    // Lane 1 alone after a compute entry must land at entry 0
    task automatic check_pointer_clear();
        drive_random(act_ram_pkg::PHASE_COMPUTE, 1'b0, 0);
        settle();
        drive_random(act_ram_pkg::PHASE_LOAD, 1'b0, 0);
        load_channel  <= 2'd2;
        load_valid    <= 2'b10;
        load_data[1]  <= 16'h5a5a;
        load_index[1] <= 4'h9;
        settle();
        drive_random(act_ram_pkg::PHASE_COMPUTE, 1'b0, 0);
        fetch_channel <= 2'd2;
        fetch_base    <= '0;
        fetch_full    <= 1'b1;
        settle();
        drive_random(act_ram_pkg::PHASE_IDLE, 1'b0, 0);
        settle();
        check_value("fetch_data[0]", fetch_data[0], 16'h5a5a);
        check_value("fetch_index[0]", fetch_index[0], 4'h9);
    endtask

    initial begin
        seed          = 57;
        rst           = 1'b1;
        phase         = act_ram_pkg::PHASE_IDLE;
        layer_parity  = 1'b0;
        busy          = 1'b0;
        load_valid    = '0;
        load_data     = '0;
        load_index    = '0;
        load_channel  = '0;
        fetch_channel = '0;
        fetch_base    = '0;
        fetch_remain  = '0;
        fetch_full    = 1'b0;
        ppu_valid     = '0;
        ppu_data      = '0;
        ppu_index     = '0;
        ppu_channel   = '0;
        count_valid   = 1'b0;
        count_value   = '0;
        model_reset();
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        run_phase(act_ram_pkg::PHASE_LOAD, 1'b0, 40, 20);
        run_phase(act_ram_pkg::PHASE_COMPUTE, 1'b0, 30, 20);
        run_phase(act_ram_pkg::PHASE_DRAIN, 1'b0, 30, 20);   // Fills bank 1
        run_phase(act_ram_pkg::PHASE_COMPUTE, 1'b1, 30, 20); // Drained data back out
        run_phase(act_ram_pkg::PHASE_COMPUTE, 1'b0, 20, 20); // Bank 0 untouched
        run_phase(act_ram_pkg::PHASE_IDLE, 1'b1, 10, 20);
        run_phase(act_ram_pkg::PHASE_LOAD, 1'b1, 10, 30);
        check_pointer_clear();

        $display("Verification passed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: run timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("Verification failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== tb.f ====
+incdir+bench
hdl/act_ram_pkg.sv
hdl/phase_decode.sv
hdl/activation_banks.sv
hdl/window_fetch.sv
hdl/act_ram_top.sv
bench/act_ram_props.sv
bench/tb_act_ram.sv

// ==== Bender.yml ====
package:
  name: act_ram

sources:
  - files:
      - hdl/act_ram_pkg.sv
      - hdl/phase_decode.sv
      - hdl/activation_banks.sv
      - hdl/window_fetch.sv
      - hdl/act_ram_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/act_ram_props.sv
      - bench/tb_act_ram.sv
